/* all.f */
hdl/QuplsPkg.sv
hdl/quplsDecodeMacro.sv
hdl/quplsInstrQueue.sv
hdl/quplsMicroSeq.sv
hdl/quplsDecodeTop.sv
testbench/quplsDecode_checker.sv
testbench/quplsDecodeTb.sv

/* hdl/QuplsPkg.sv */
// Shared types and constants for the decode front; INSTR_QDEPTH must match the sender's credits
`default_nettype none

package QuplsPkg;

// ==========================================================================
// Field widths
// ==========================================================================

	// The instruction word is a fixed 32 bits wide
	localparam int INSTR_BITS = 32;

	// The opcode sits in the low seven bits of every word
	localparam int OPC_BITS = 7;

	// The macro count field holds up to eight steps, numbered 0 to 7
	localparam int STEP_BITS = 3;

	// The count field starts at bit 8 and ends at bit 10
	localparam int CNT_LSB = 8;

	typedef logic [INSTR_BITS-1:0] instrWord_t;
	typedef logic [OPC_BITS-1:0] opcode_t;
	typedef logic [STEP_BITS-1:0] stepIdx_t;

// ==========================================================================
// Macro opcodes
// ==========================================================================

	// Stack frame group
	localparam opcode_t OP_PUSH  = 7'h10;
	localparam opcode_t OP_POP   = 7'h11;
	localparam opcode_t OP_ENTER = 7'h12;
	localparam opcode_t OP_LEAVE = 7'h13;

	// Bit string group
	localparam opcode_t OP_BSET  = 7'h14;
	localparam opcode_t OP_BFND  = 7'h15;
	localparam opcode_t OP_BMOV  = 7'h16;
	localparam opcode_t OP_BCMP  = 7'h17;

	// Indirect subroutine call through a table
	localparam opcode_t OP_JSRI  = 7'h18;

// ==========================================================================
// Flow control
// ==========================================================================

	// Queue entries, which is also the sender's starting credit count
	localparam int INSTR_QDEPTH = 4;

	// Micro-op credits the rename side grants after reset
	localparam int UOP_CREDITS = 4;

	// Three bits hold any count from 0 up to 4
	typedef logic [2:0] credit_t;

	// Queue pointers index one of INSTR_QDEPTH entries
	localparam int QPTR_BITS = $clog2(INSTR_QDEPTH);
	typedef logic [QPTR_BITS-1:0] qPtr_t;

endpackage

`default_nettype wire

/* hdl/quplsDecodeMacro.sv */
// Purely combinational; looks only at the opcode field, so the count field is ignored here
`default_nettype none

module quplsDecodeMacro
(
	input wire QuplsPkg::instrWord_t instr,
	output logic isMacro
);

	// Opcode pulled out of the low bits of the word
	QuplsPkg::opcode_t opcode;

	assign opcode = instr[QuplsPkg::OPC_BITS-1:0];

	// Any of the nine macro opcodes expands into several micro-ops
	always_comb
	begin
		unique case (opcode)
		QuplsPkg::OP_PUSH, QuplsPkg::OP_POP:
			isMacro = 1'b1;
		QuplsPkg::OP_ENTER, QuplsPkg::OP_LEAVE:
			isMacro = 1'b1;
		QuplsPkg::OP_BSET, QuplsPkg::OP_BFND, QuplsPkg::OP_BMOV, QuplsPkg::OP_BCMP:
			isMacro = 1'b1;
		QuplsPkg::OP_JSRI:
			isMacro = 1'b1;
		// Everything else is a plain single micro-op word
		default:
			isMacro = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/quplsDecodeTop.sv */
// At least two cycles from instrValid to the first uopValid; both sides run on credits only
`default_nettype none

module quplsDecodeTop
(
	input wire clk,
	input wire rstN,
	input wire instrValid,
	input wire QuplsPkg::instrWord_t instrData,
	output logic instrCredit,
	output logic uopValid,
	output QuplsPkg::instrWord_t uopData,
	output QuplsPkg::stepIdx_t uopStep,
	output logic uopLast,
	input wire uopCredit
);

	// Head of the instruction queue and the pop from the sequencer
	logic qValid;
	QuplsPkg::instrWord_t qData;
	logic qPop;

	quplsInstrQueue i_quplsInstrQueue
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrData(instrData),
		.pop(qPop),
		.headValid(qValid),
		.headData(qData),
		.instrCredit(instrCredit)
	);

	// Expands each queued word into its run of micro-ops
	quplsMicroSeq i_quplsMicroSeq
	(
		.clk(clk),
		.rstN(rstN),
		.qValid(qValid),
		.qData(qData),
		.qPop(qPop),
		.uopValid(uopValid),
		.uopData(uopData),
		.uopStep(uopStep),
		.uopLast(uopLast),
		.uopCredit(uopCredit)
	);

endmodule

`default_nettype wire

/* hdl/quplsInstrQueue.sv */
// Sender must respect credits; a write into a full queue is not detected and corrupts entries
`default_nettype none

module quplsInstrQueue
(
	input wire clk,
	input wire rstN,
	input wire instrValid,
	input wire QuplsPkg::instrWord_t instrData,
	input wire pop,
	output logic headValid,
	output QuplsPkg::instrWord_t headData,
	output logic instrCredit
);

	// Entry storage
	QuplsPkg::instrWord_t mem [QuplsPkg::INSTR_QDEPTH];

	// Circular pointers and the number of valid entries
	QuplsPkg::qPtr_t wrPtr;
	QuplsPkg::qPtr_t rdPtr;
	QuplsPkg::credit_t count;

	// A pop only counts when there is an entry to take
	logic doPop;

	// Advance a pointer and wrap at the last entry
	function automatic QuplsPkg::qPtr_t nextPtr(input QuplsPkg::qPtr_t ptr);
		if (ptr == QuplsPkg::qPtr_t'(QuplsPkg::INSTR_QDEPTH - 1))
			return '0;
		return ptr + QuplsPkg::qPtr_t'(1);
	endfunction

	assign headValid = (count != '0);
	assign headData = mem[rdPtr];
	assign doPop = pop & headValid;

	// A written word shows up at the head on the following cycle
	always_ff @(posedge clk)
	begin
		if (instrValid)
			mem[wrPtr] <= instrData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			instrCredit <= 1'b0;
		end
		else
		begin
			if (instrValid)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			// Simultaneous write and pop leave the occupancy unchanged
			unique case ({instrValid, doPop})
			2'b10:
				count <= count + QuplsPkg::credit_t'(1);
			2'b01:
				count <= count - QuplsPkg::credit_t'(1);
			default:
				count <= count;
			endcase
			// One credit goes back to the sender the cycle after each pop
			instrCredit <= doPop;
		end
	end

endmodule

`default_nettype wire

/* hdl/quplsMicroSeq.sv */
// Emits only while holding output credit; receiver must not return more than UOP_CREDITS
`default_nettype none

module quplsMicroSeq
(
	input wire clk,
	input wire rstN,
	input wire qValid,
	input wire QuplsPkg::instrWord_t qData,
	output logic qPop,
	output logic uopValid,
	output QuplsPkg::instrWord_t uopData,
	output QuplsPkg::stepIdx_t uopStep,
	output logic uopLast,
	input wire uopCredit
);

	typedef enum logic
	{
		IDLE,
		EMIT
	} seqState_t;

	seqState_t state;

	// Word being expanded, current step and the step that ends it
	QuplsPkg::instrWord_t wordReg;
	QuplsPkg::stepIdx_t stepCnt;
	QuplsPkg::stepIdx_t finalStep;

	// Micro-op slots still granted by the rename side
	QuplsPkg::credit_t creditCnt;

	// Macro flag and count field of the word at the queue head
	logic headIsMacro;
	QuplsPkg::stepIdx_t headCount;

	// High in any cycle that sends a micro-op
	logic emit;

// ==========================================================================
// Head decode
// ==========================================================================

	quplsDecodeMacro i_quplsDecodeMacro
	(
		.instr(qData),
		.isMacro(headIsMacro)
	);

	assign headCount = qData[QuplsPkg::CNT_LSB +: QuplsPkg::STEP_BITS];

// ==========================================================================
// Micro-op output
// ==========================================================================

	assign emit = (state == EMIT) && (creditCnt != '0);
	assign uopValid = emit;
	assign uopData = wordReg;
	assign uopStep = stepCnt;
	assign uopLast = (stepCnt == finalStep);

	// Take a new word when idle, or in the same cycle the last step goes out
	assign qPop = qValid && ((state == IDLE) || (emit && uopLast));

	// Word captured on each pop and held for all of its steps
	always_ff @(posedge clk)
	begin
		if (qPop)
			wordReg <= qData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			stepCnt <= '0;
			finalStep <= '0;
		end
		else if (qPop)
		begin
			// A plain word ends on step 0, a macro on its count field
			state <= EMIT;
			stepCnt <= '0;
			finalStep <= headIsMacro ? headCount : '0;
		end
		else if (emit)
		begin
			if (uopLast)
				state <= IDLE;
			else
				stepCnt <= stepCnt + QuplsPkg::stepIdx_t'(1);
		end
	end

	// Returned credits and sent micro-ops can land in the same cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			creditCnt <= QuplsPkg::credit_t'(QuplsPkg::UOP_CREDITS);
		else
		begin
			unique case ({uopCredit, emit})
			2'b10:
				creditCnt <= creditCnt + QuplsPkg::credit_t'(1);
			2'b01:
				creditCnt <= creditCnt - QuplsPkg::credit_t'(1);
			default:
				creditCnt <= creditCnt;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the decode front testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module quplsDecodeTb -f all.f -o simDecode

# A failing run still leaves its log for the search below
./obj_dir/simDecode > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log
then
	exit 0
fi
exit 1

/* testbench/decodeStim.txt */
# Columns: instruction word (hex), cycles to withhold output credit after the send (decimal),
# expected micro-op count (decimal). Opcode is bits 6:0, macro count field is bits 10:8.
00000033 0 1
12340310 3 4
00a00011 0 1
0f000712 12 8
00000113 1 2
dead0514 0 6
00000733 0 1
55aa0215 5 3
00040616 2 7
80000417 20 5
7fff0718 0 8
00000519 0 1
0000030f 1 1
00000018 0 1

/* testbench/quplsDecodeTb.sv */
// Run from the project root so testbench/decodeStim.txt is found; the first mismatch ends the run
`default_nettype none

module quplsDecodeTb;

	// Wait limits in clock cycles, and room in the log of sent words
	localparam int SEND_WAIT = 200;
	localparam int DRAIN_WAIT = 3000;
	localparam int MAX_WORDS = 64;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic instrValid = 1'b0;
	QuplsPkg::instrWord_t instrData = '0;
	logic uopCredit = 1'b0;
	logic instrCredit;
	logic uopValid;
	QuplsPkg::instrWord_t uopData;
	QuplsPkg::stepIdx_t uopStep;
	logic uopLast;

	// The stimulus process owns the sender side
	QuplsPkg::instrWord_t sentLog [MAX_WORDS];
	int inCredit = QuplsPkg::INSTR_QDEPTH;
	int creditsBack = 0;
	int wordsSent = 0;
	int uopsExpected = 0;
	int holdUntil = 0;

	// The monitor owns the receiver side and walks the expected expansion with wordIdx and stepIdx
	int heldCredits = 0;
	int uopsSeen = 0;
	int cycleCnt = 0;
	int wordIdx = 0;
	int stepIdx = 0;
	logic [31:0] rngState = 32'hde2e_dc5a;

	quplsDecodeTop i_quplsDecodeTop
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrData(instrData),
		.instrCredit(instrCredit),
		.uopValid(uopValid),
		.uopData(uopData),
		.uopStep(uopStep),
		.uopLast(uopLast),
		.uopCredit(uopCredit)
	);

	always #4 clk = ~clk;

// ==========================================================================
// Helpers
// ==========================================================================

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Opcodes 0x10 to 0x18 expand into count+1 micro-ops and anything else into one
	function automatic int expandLen(input QuplsPkg::instrWord_t w);
		QuplsPkg::opcode_t opc;
		opc = w[6:0];
		if (opc >= QuplsPkg::OP_PUSH && opc <= QuplsPkg::OP_JSRI)
			return int'(w[10:8]) + 1;
		return 1;
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopping on the first mismatch");
		end
	endtask

	task automatic giveUp(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "wait loop expired");
	endtask

	// One clock edge on the sender side, where returned input credits are collected
	task automatic tick();
		@(posedge clk);
		instrValid <= 1'b0;
		if (instrCredit)
		begin
			inCredit++;
			creditsBack++;
		end
		checkEq(32'(inCredit <= QuplsPkg::INSTR_QDEPTH), 32'd1, "input credits within queue depth");
	endtask

	// Sends one word once a credit is held, then withholds output credit for gap cycles
	task automatic sendWord(input QuplsPkg::instrWord_t w, input int gap);
		int waited;
		waited = 0;
		checkEq(32'(wordsSent < MAX_WORDS), 32'd1, "stimulus fits the word log");
		tick();
		while (inCredit == 0)
		begin
			waited++;
			if (waited > SEND_WAIT)
				giveUp("an input credit");
			tick();
		end
		instrValid <= 1'b1;
		instrData <= w;
		sentLog[wordsSent] <= w;
		holdUntil <= cycleCnt + gap;
		inCredit--;
		wordsSent++;
		uopsExpected += expandLen(w);
	endtask

	// Compares one micro-op with the next step of the oldest unfinished word
	task automatic takeUop();
		int n;
		checkEq(32'(wordIdx < wordsSent), 32'd1, "micro-op with no word left to expand");
		n = expandLen(sentLog[wordIdx]);
		checkEq(uopData, sentLog[wordIdx], "uopData");
		checkEq(32'(uopStep), 32'(stepIdx), "uopStep");
		checkEq(32'(uopLast), 32'(stepIdx == n - 1), "uopLast");
		heldCredits++;
		uopsSeen <= uopsSeen + 1;
		if (stepIdx == n - 1)
		begin
			wordIdx++;
			stepIdx = 0;
		end
		else
			stepIdx++;
	endtask

// ==========================================================================
// Receiver with random credit return
// ==========================================================================

	always @(posedge clk)
	begin
		cycleCnt <= cycleCnt + 1;
		checkEq(32'(i_quplsDecodeTop.i_quplsMicroSeq.i_quplsDecodeChecker.failTotal), 32'd0,
			"bound assertion failures");
		if (!rstN)
			uopCredit <= 1'b0;
		else
		begin
			if (uopValid)
				takeUop();
			// Never more in flight than the credits granted at reset
			checkEq(32'(heldCredits <= QuplsPkg::UOP_CREDITS), 32'd1,
				"micro-ops outstanding within output credits");
			rngState = nextRand(rngState);
			if (heldCredits > 0 && cycleCnt >= holdUntil && rngState[16])
			begin
				uopCredit <= 1'b1;
				heldCredits--;
			end
			else
				uopCredit <= 1'b0;
		end
	end

// ==========================================================================
// Stimulus
// ==========================================================================

	initial
	begin
		int fd;
		int fields;
		int gap;
		int fileUops;
		int waited;
		string line;
		QuplsPkg::instrWord_t word;

		// First edge lets the async reset settle, then both outputs must stay low
		tick();
		for (int i = 0; i < 9; i++)
		begin
			tick();
			checkEq(32'(instrCredit), 32'd0, "instrCredit during reset");
			checkEq(32'(uopValid), 32'd0, "uopValid during reset");
		end
		rstN <= 1'b1;
		for (int i = 0; i < 2; i++)
		begin
			tick();
			checkEq(32'(instrCredit), 32'd0, "instrCredit after reset");
			checkEq(32'(uopValid), 32'd0, "uopValid after reset");
		end

		fd = $fopen("testbench/decodeStim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file testbench/decodeStim.txt");
			$display("TB FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines never parse as three fields
			fields = $sscanf(line, "%h %d %d", word, gap, fileUops);
			if (fields == 3)
			begin
				checkEq(32'(expandLen(word)), 32'(fileUops), "micro-op count in the stimulus file");
				sendWord(word, gap);
			end
		end
		$fclose(fd);

		// Drain until every expected micro-op is in, by then the last pop has returned its credit
		waited = 0;
		while (uopsSeen != uopsExpected)
		begin
			waited++;
			if (waited > DRAIN_WAIT)
				giveUp("the last micro-ops");
			tick();
		end
		checkEq(32'(creditsBack), 32'(wordsSent), "instrCredit pulses against words sent");
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/quplsDecode_checker.sv */
// Bound into quplsMicroSeq; failTotal counts assertion failures for the testbench to read
`default_nettype none

module quplsDecode_checker
(
	input wire clk,
	input wire rstN,
	input wire uopValid,
	input wire QuplsPkg::stepIdx_t uopStep,
	input wire uopLast,
	input wire uopCredit,
	input wire QuplsPkg::credit_t creditCnt
);

	// One count per assertion
	int creditFails = 0;
	int validFails = 0;
	int stepFails = 0;
	int failTotal;

	// Step of the previous micro-op and whether its word still has steps to go
	QuplsPkg::stepIdx_t prevStep;
	logic midWord;

	// Micro-ops sent and not yet matched by a credit coming back from the receiver
	int inFlight;

	assign failTotal = creditFails + validFails + stepFails;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			prevStep <= '0;
			midWord <= 1'b0;
		end
		else if (uopValid)
		begin
			prevStep <= uopStep;
			midWord <= !uopLast;
		end
	end

	// Counted from the handshakes alone, apart from the sequencer's own counter
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			inFlight <= 0;
		else
			inFlight <= inFlight + int'(uopValid) - int'(uopCredit);
	end

	// Returned credits never lift the counter past its reset value
	creditMax: assert property (@(posedge clk) disable iff (!rstN)
		creditCnt <= QuplsPkg::credit_t'(QuplsPkg::UOP_CREDITS))
	else
	begin
		$error("output credit counter above UOP_CREDITS");
		creditFails++;
	end

	// With every granted credit already in flight no further micro-op may go out
	validCredit: assert property (@(posedge clk) disable iff (!rstN)
		uopValid |-> inFlight < QuplsPkg::UOP_CREDITS)
	else
	begin
		$error("micro-op sent with no output credit");
		validFails++;
	end

	// A new word starts at step 0, later steps climb by one
	stepOrder: assert property (@(posedge clk) disable iff (!rstN)
		uopValid |-> uopStep == (midWord ? QuplsPkg::stepIdx_t'(prevStep + 1'b1) : '0))
	else
	begin
		$error("micro-op step out of sequence");
		stepFails++;
	end

endmodule

bind quplsMicroSeq quplsDecode_checker i_quplsDecodeChecker
(
	.clk(clk),
	.rstN(rstN),
	.uopValid(uopValid),
	.uopStep(uopStep),
	.uopLast(uopLast),
	.uopCredit(uopCredit),
	.creditCnt(creditCnt)
);

`default_nettype wire
